/* all.f */
+incdir+verification
src/mul_pkg.sv
src/mul_decode.sv
src/mul_req_fifo.sv
src/mul_unit.sv
src/mul_retire.sv
src/mul_top.sv
verification/tb_mul_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the multiply unit testbench with Verilator and runs it
# The run fails when a command fails or the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_mul_top \
    -Mdir obj_dir -o tb_mul_top \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mul_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

/* verification/mul_model.svh */
`ifndef MUL_MODEL_SVH
`define MUL_MODEL_SVH

// Reference model of the multiply unit, included inside the testbench module

// Major opcodes and funct7 of the M-extension as the ISA defines them
localparam logic [6:0] OP_MAJOR   = 7'b0110011;
localparam logic [6:0] OP32_MAJOR = 7'b0111011;
localparam logic [6:0] MULDIV_F7  = 7'b0000001;

// Shadow of the destination register file, updated as results retire
xlen_t shadow_rf [32] = '{default: '0};

// Returns 1 for a multiply and gives its operation, 0 for anything else
function automatic bit decode_instr(input instr_t w, output mul_op_e op);
    bit ok;
    ok = 1'b0;
    op = MUL;
    if (w[31:25] == MULDIV_F7 && w[6:0] == OP_MAJOR && !w[14]) begin
        // Funct3 0 to 3 are the multiplies, 4 to 7 are divide and remainder
        ok = 1'b1;
        case (w[13:12])
            2'd0:    op = MUL;
            2'd1:    op = MULH;
            2'd2:    op = MULHSU;
            default: op = MULHU;
        endcase
    end else if (w[31:25] == MULDIV_F7 && w[6:0] == OP32_MAJOR && w[14:12] == 3'd0) begin
        ok = 1'b1;
        op = MULW;
    end
    return ok;
endfunction

// Full 128-bit product, then the slice that the operation returns
function automatic xlen_t expected_product(mul_op_e op, xlen_t a, xlen_t b);
    logic signed [127:0] sa;
    logic signed [127:0] sb;
    logic [127:0]        p;
    sa = {{64{a[63]}}, a};
    sb = {{64{b[63]}}, b};
    case (op)
        MULH: p = sa * sb;
        MULHSU: begin
            // Second operand taken as unsigned
            sb = {64'd0, b};
            p  = sa * sb;
        end
        default: p = {64'd0, a} * {64'd0, b};
    endcase
    case (op)
        MULH, MULHSU, MULHU: return p[127:64];
        MULW:                return {{32{p[31]}}, p[31:0]};
        default:             return p[63:0];
    endcase
endfunction

// What the writeback shows, a result aimed at x0 carries zero
function automatic xlen_t expected_wb_data(mul_op_e op, reg_idx_t rd, xlen_t a, xlen_t b);
    if (rd == '0) begin
        return '0;
    end
    return expected_product(op, a, b);
endfunction

function automatic void shadow_write(reg_idx_t rd, xlen_t d);
    // x0 is hardwired to zero
    if (rd != '0) begin
        shadow_rf[rd] = d;
    end
endfunction

function automatic xlen_t shadow_read(reg_idx_t idx);
    return (idx == '0) ? '0 : shadow_rf[idx];
endfunction

`endif

/* verification/tb_mul_top.sv */
`timescale 1ns/1ps

module tb_mul_top import mul_pkg::*; ();

    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int RANDOM_COUNT  = 300;
    localparam int BURST_COUNT   = 12;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    instr_t   instr;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    logic     illegal;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    reg_idx_t rf_raddr;
    xlen_t    rf_rdata;

    // Expected writebacks of the accepted legal instructions, oldest first
    reg_idx_t exp_rd_q [$];
    xlen_t    exp_data_q [$];

    int value_errors  = 0;
    int other_errors  = 0;
    int wb_count      = 0;
    int legal_count   = 0;
    int illegal_count = 0;
    int x0_writes     = 0;

    bit pend_illegal    = 1'b0;
    bit timed_out       = 1'b0;
    bit ready_low_seen  = 1'b0;
    bit ready_recovered = 1'b0;

    `include "mul_model.svh"

    mul_top #(
        .QUEUE_DEPTH (4)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .instr    (instr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .illegal  (illegal),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Builds an R-type multiply word
    function automatic instr_t encode_mul(mul_op_e op, reg_idx_t rd, logic [4:0] rs1f,
                                          logic [4:0] rs2f);
        instr_t w;
        case (op)
            MULH:    w = {MULDIV_F7, rs2f, rs1f, 3'd1, rd, OP_MAJOR};
            MULHSU:  w = {MULDIV_F7, rs2f, rs1f, 3'd2, rd, OP_MAJOR};
            MULHU:   w = {MULDIV_F7, rs2f, rs1f, 3'd3, rd, OP_MAJOR};
            MULW:    w = {MULDIV_F7, rs2f, rs1f, 3'd0, rd, OP32_MAJOR};
            default: w = {MULDIV_F7, rs2f, rs1f, 3'd0, rd, OP_MAJOR};
        endcase
        return w;
    endfunction

    // About 85% multiplies, the rest divides, other ALU ops or raw words
    function automatic instr_t random_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        mul_op_e     op;
        instr_t      w;
        r  = $urandom;
        f3 = (r[14:12] == 3'd0) ? 3'd1 : r[14:12];
        if ($urandom_range(99, 0) < 85) begin
            case ($urandom_range(4, 0))
                0:       op = MUL;
                1:       op = MULH;
                2:       op = MULHSU;
                3:       op = MULHU;
                default: op = MULW;
            endcase
            w = encode_mul(op, r[11:7], r[19:15], r[24:20]);
        end else begin
            case (r[1:0])
                2'd0:    w = {MULDIV_F7, r[24:15], 1'b1, r[13:12], r[11:7], OP_MAJOR};
                2'd1:    w = {MULDIV_F7, r[24:15], f3, r[11:7], OP32_MAJOR};
                2'd2:    w = {7'b0000000, r[24:7], OP_MAJOR};
                default: w = $urandom;
            endcase
        end
        return w;
    endfunction

    // Random, small, signed extreme or all-ones operand
    function automatic xlen_t random_operand();
        xlen_t v;
        case ($urandom_range(3, 0))
            0: v = {$urandom, $urandom};
            1: v = {32'd0, $urandom};
            2: begin
                case ($urandom_range(3, 0))
                    0:       v = 64'h8000_0000_0000_0000;
                    1:       v = 64'h7fff_ffff_ffff_ffff;
                    2:       v = 64'h0000_0000_ffff_ffff;
                    default: v = 64'hffff_ffff_8000_0000;
                endcase
            end
            default: v = '1;
        endcase
        return v;
    endfunction

    // Starts right after a rising edge and returns after the accepting edge
    task automatic issue(input instr_t word, input xlen_t a, input xlen_t b);
        int waited;
        waited = 0;
        instr    <= word;
        rs1_val  <= a;
        rs2_val  <= b;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready && waited < ISSUE_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!in_ready) begin
            $display("Timed out at %0t waiting for the DUT to take an instruction", $time);
            timed_out = 1'b1;
            other_errors++;
        end
        @(posedge clk);
        if (timed_out) begin
            in_valid <= 1'b0;
        end
    endtask

    task automatic idle_cycle();
        in_valid <= 1'b0;
        @(posedge clk);
    endtask

    // Waits until every legal instruction has retired
    task automatic wait_drain();
        int waited;
        waited = 0;
        in_valid <= 1'b0;
        while ((exp_rd_q.size() != 0 || pend_illegal) && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (exp_rd_q.size() != 0) begin
            $display("Timed out at %0t with %0d results still outstanding", $time,
                     exp_rd_q.size());
            timed_out = 1'b1;
            other_errors++;
        end
        // A duplicated or stray result would still show up in this window
        repeat (16) @(negedge clk);
    endtask

    // Reads every register through the read port against the shadow file
    task automatic check_registers();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rf_raddr <= r[4:0];
            @(negedge clk);
            assert (rf_rdata == shadow_read(r[4:0])) else begin
                value_errors++;
                $display("ERR %0t: x%0d reads %h, expected %h", $time, r, rf_rdata,
                         shadow_read(r[4:0]));
            end
        end
    endtask

    // Samples on the falling edge where all DUT outputs are settled
    initial begin : scoreboard
        reg_idx_t exp_rd;
        xlen_t    exp_data;
        mul_op_e  op;
        bit       legal;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (wb_valid) begin
                    wb_count++;
                    assert (exp_rd_q.size() != 0) else begin
                        other_errors++;
                        $display("Writeback to x%0d at %0t with nothing outstanding", wb_rd,
                                 $time);
                    end
                    if (exp_rd_q.size() != 0) begin
                        exp_rd   = exp_rd_q.pop_front();
                        exp_data = exp_data_q.pop_front();
                        assert (wb_rd == exp_rd && wb_data == exp_data) else begin
                            value_errors++;
                            $display("ERR %0t: writeback x%0d %h, expected x%0d %h", $time,
                                     wb_rd, wb_data, exp_rd, exp_data);
                        end
                        if (exp_rd == '0) begin
                            x0_writes++;
                        end
                        shadow_write(exp_rd, exp_data);
                    end
                end
                // The pulse belongs to the instruction taken on the previous edge
                assert (illegal == pend_illegal) else begin
                    value_errors++;
                    $display("ERR %0t: illegal is %b, expected %b", $time, illegal,
                             pend_illegal);
                end
                pend_illegal = 1'b0;
                // Both high here means the DUT takes the instruction on the next edge
                if (in_valid && in_ready) begin
                    legal = decode_instr(instr, op);
                    if (legal) begin
                        legal_count++;
                        exp_rd_q.push_back(instr[11:7]);
                        exp_data_q.push_back(expected_wb_data(op, instr[11:7], rs1_val,
                                                              rs2_val));
                    end else begin
                        illegal_count++;
                        pend_illegal = 1'b1;
                    end
                end
                if (!in_ready) begin
                    ready_low_seen = 1'b1;
                end else if (ready_low_seen) begin
                    ready_recovered = 1'b1;
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'h10a7_bc04));
        rst      = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        rf_raddr = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!wb_valid && !illegal) else begin
            value_errors++;
            $display("ERR %0t: wb_valid %b illegal %b after reset", $time, wb_valid, illegal);
        end
        check_registers();
        @(posedge clk);

        // Directed cases: fast and full MUL, MULW sign, high forms at the extremes
        issue(encode_mul(MUL, 5'd1, 5'd2, 5'd3), 64'h0000_0000_ffff_ffff,
              64'h0000_0000_1234_5678);
        issue(encode_mul(MUL, 5'd2, 5'd2, 5'd3), 64'h8000_0000_0000_0001, '1);
        issue(encode_mul(MULW, 5'd3, 5'd2, 5'd3), 64'h1234_5678_0001_0000, 64'h8000);
        issue(encode_mul(MULH, 5'd4, 5'd2, 5'd3), 64'h8000_0000_0000_0000,
              64'h8000_0000_0000_0000);
        issue(encode_mul(MULHSU, 5'd5, 5'd2, 5'd3), '1, '1);
        issue(encode_mul(MULHU, 5'd6, 5'd2, 5'd3), '1, '1);
        issue(encode_mul(MUL, 5'd0, 5'd2, 5'd3), 64'd7, 64'd9);
        // DIV followed by a legal multiply
        issue({MULDIV_F7, 5'd3, 5'd2, 3'd4, 5'd7, OP_MAJOR}, 64'd100, 64'd5);
        issue(encode_mul(MUL, 5'd7, 5'd2, 5'd3), 64'd100, 64'd5);

        for (int i = 0; i < RANDOM_COUNT && !timed_out; i++) begin
            issue(random_instr(), random_operand(), random_operand());
            if ($urandom_range(7, 0) == 0) begin
                idle_cycle();
            end
        end

        // Back-to-back high products fill the queue behind the busy multiplier
        ready_low_seen  = 1'b0;
        ready_recovered = 1'b0;
        for (int i = 0; i < BURST_COUNT && !timed_out; i++) begin
            issue(encode_mul((i % 2 == 0) ? MULHU : MULH, 5'(i + 8), 5'd1, 5'd2),
                  random_operand(), random_operand());
        end
        if (!timed_out) begin
            wait_drain();
        end

        assert (ready_low_seen && ready_recovered) else begin
            other_errors++;
            $display("in_ready did not fall and recover during the burst");
        end
        assert (wb_count == legal_count) else begin
            other_errors++;
            $display("Saw %0d writebacks for %0d legal instructions", wb_count, legal_count);
        end
        assert (x0_writes > 0) else begin
            other_errors++;
            $display("No result was aimed at x0");
        end
        if (!timed_out) begin
            check_registers();
        end

        $display("Value errors %0d, other errors %0d, writebacks %0d, legal %0d, illegal %0d",
                 value_errors, other_errors, wb_count, legal_count, illegal_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src/mul_top.sv */
`timescale 1ns/1ps

module mul_top import mul_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  instr_t   instr,
    input  xlen_t    rs1_val,
    input  xlen_t    rs2_val,
    output logic     illegal,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data,
    input  reg_idx_t rf_raddr,
    output xlen_t    rf_rdata
);

    // Decoder to request queue
    logic     dec_valid;
    logic     dec_ready;
    mul_op_e  dec_op;
    reg_idx_t dec_rd;
    xlen_t    dec_a;
    xlen_t    dec_b;

    // Queue head to multiplier
    logic     q_valid;
    logic     q_ready;
    mul_op_e  q_op;
    reg_idx_t q_rd;
    xlen_t    q_a;
    xlen_t    q_b;

    // Multiplier to retire stage, always accepted
    logic     res_valid;
    reg_idx_t res_rd;
    xlen_t    res_data;

    mul_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr     (instr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .illegal   (illegal)
    );

    // The queue soaks up requests while the multiplier is busy
    mul_req_fifo #(
        .DEPTH (QUEUE_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_valid (dec_valid),
        .push_ready (dec_ready),
        .push_op    (dec_op),
        .push_rd    (dec_rd),
        .push_a     (dec_a),
        .push_b     (dec_b),
        .pop_valid  (q_valid),
        .pop_ready  (q_ready),
        .pop_op     (q_op),
        .pop_rd     (q_rd),
        .pop_a      (q_a),
        .pop_b      (q_b)
    );

    mul_unit u_mul (
        .clk       (clk),
        .rst       (rst),
        .req_valid (q_valid),
        .req_ready (q_ready),
        .req_op    (q_op),
        .req_rd    (q_rd),
        .operand1  (q_a),
        .operand2  (q_b),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

    mul_retire u_retire (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .rf_raddr  (rf_raddr),
        .rf_rdata  (rf_rdata)
    );

endmodule

/* src/mul_retire.sv */
`timescale 1ns/1ps

module mul_retire import mul_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     res_valid,
    input  reg_idx_t res_rd,
    input  xlen_t    res_data,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data,
    input  reg_idx_t rf_raddr,
    output xlen_t    rf_rdata
);

    // Destination register file, entry 0 is never written
    xlen_t rf [32];

    logic rf_we;

    // Writes aimed at x0 are dropped
    assign rf_we = res_valid && (res_rd != '0);

    // Register file update, cleared as a whole on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[res_rd] <= res_data;
        end
    end

    // Writeback strobe, lands on the same edge as the register write
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= res_valid;
        end
    end

    // Writeback payload
    // A result for x0 still shows up on the strobe but carries zero
    always_ff @(posedge clk) begin
        if (res_valid) begin
            wb_rd   <= res_rd;
            wb_data <= (res_rd == '0) ? '0 : res_data;
        end
    end

    // Combinational read port
    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];

endmodule

/* src/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mul_op_e  req_op,
    input  reg_idx_t req_rd,
    input  xlen_t    operand1,
    input  xlen_t    operand2,
    output logic     res_valid,
    output reg_idx_t res_rd,
    output xlen_t    res_data
);

    mul_state_e state;

    // Operands widened to 65 bits so that signed and unsigned forms share one
    // datapath
    logic [64:0] mul_a;
    logic [64:0] mul_b;

    // Per-request flags taken at accept
    logic mul_word;
    logic mul_high;
    logic mul_fast;

    logic               req_fire;
    logic               sext_a;
    logic               sext_b;
    logic [32:0]        mac_a;
    logic [32:0]        mac_b;
    logic signed [65:0] acc;
    logic signed [65:0] prod;
    logic [65:0]        acc_shift;

    // Only an idle multiplier takes a new request
    assign req_ready = (state == IDLE);
    assign req_fire  = req_valid && req_ready;

    // MULH treats both operands as signed, MULHSU only the first one
    assign sext_a = (req_op == MULH) || (req_op == MULHSU);
    assign sext_b = (req_op == MULH);

    // The state bits pick which 33-bit slice of each operand enters the step
    // Lower slices get a zero on top so they stay positive in the signed multiply
    assign mac_a = state[1] ? mul_a[64:32] : {1'b0, mul_a[31:0]};
    assign mac_b = state[0] ? mul_b[64:32] : {1'b0, mul_b[31:0]};

    // One 33x33 signed multiply-accumulate per step
    assign prod = acc + $signed(mac_a) * $signed(mac_b);

    // Moves the accumulator on to the next 32-bit column, keeping the sign
    assign acc_shift = {{32{prod[65]}}, prod[65:32]};

    // Step sequence and the result strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_fire) begin
                        state <= LL;
                    end
                end
                LL: begin
                    // A word multiply or a small MUL is done after one step
                    if (mul_word || mul_fast) begin
                        res_valid <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        state <= HL;
                    end
                end
                HL: begin
                    state <= LH;
                end
                LH: begin
                    // The low product is complete once both cross terms are in
                    if (mul_high) begin
                        state <= HH;
                    end else begin
                        res_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                HH: begin
                    res_valid <= 1'b1;
                    state     <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operands, accumulator and result assembly
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (req_fire) begin
                    mul_a    <= {sext_a && operand1[63], operand1};
                    mul_b    <= {sext_b && operand2[63], operand2};
                    res_rd   <= req_rd;
                    mul_word <= (req_op == MULW);
                    mul_high <= (req_op == MULH) || (req_op == MULHSU) ||
                                (req_op == MULHU);
                    // Refreshed on every accept so an old request cannot leak in
                    mul_fast <= (req_op == MUL) && (operand1[63:32] == 32'd0) &&
                                (operand2[63:32] == 32'd0);
                    acc      <= '0;
                end
            end
            LL: begin
                res_data[31:0] <= prod[31:0];
                if (mul_word) begin
                    res_data[63:32] <= {32{prod[31]}};
                end else if (mul_fast) begin
                    // Both upper halves are zero, so the low product is the full one
                    res_data[63:32] <= prod[63:32];
                end
                acc <= acc_shift;
            end
            HL: begin
                // Same column as LH, so no shift here
                acc <= prod;
            end
            LH: begin
                res_data[63:32] <= prod[31:0];
                acc             <= acc_shift;
            end
            HH: begin
                // Bits 127:64 of the full product
                res_data <= prod[63:0];
            end
            default: begin
            end
        endcase
    end

    // The retire stage counts each strobe as one result
    a_res_pulse: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> !res_valid);

endmodule

/* src/mul_req_fifo.sv */
`timescale 1ns/1ps

module mul_req_fifo import mul_pkg::*; #(
    parameter int unsigned DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_valid,
    output logic     push_ready,
    input  mul_op_e  push_op,
    input  reg_idx_t push_rd,
    input  xlen_t    push_a,
    input  xlen_t    push_b,
    output logic     pop_valid,
    input  logic     pop_ready,
    output mul_op_e  pop_op,
    output reg_idx_t pop_rd,
    output xlen_t    pop_a,
    output xlen_t    pop_b
);

    // DEPTH is a power of two so the pointers wrap on their own
    localparam int unsigned AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL = (AW + 1)'(DEPTH);

    mul_op_e  op_mem [DEPTH];
    reg_idx_t rd_mem [DEPTH];
    xlen_t    a_mem  [DEPTH];
    xlen_t    b_mem  [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push_fire;
    logic          pop_fire;

    assign push_ready = (count != FULL);
    assign pop_valid  = (count != '0);
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    // Head of the queue goes straight to the multiplier
    assign pop_op = op_mem[rd_ptr];
    assign pop_rd = rd_mem[rd_ptr];
    assign pop_a  = a_mem[rd_ptr];
    assign pop_b  = b_mem[rd_ptr];

    // Pointers and occupancy, a push and a pop may happen in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            op_mem[wr_ptr] <= push_op;
            rd_mem[wr_ptr] <= push_rd;
            a_mem[wr_ptr]  <= push_a;
            b_mem[wr_ptr]  <= push_b;
        end
    end

    // Occupancy never passes the depth, which a push into a full queue would cause
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        count <= FULL);

    // The pointer distance follows the occupancy, so the read side never runs
    // ahead of what was written
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        AW'(wr_ptr - rd_ptr) == count[AW-1:0]);

endmodule

/* src/mul_decode.sv */
`timescale 1ns/1ps

module mul_decode import mul_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  instr_t   instr,
    input  xlen_t    rs1_val,
    input  xlen_t    rs2_val,
    output logic     dec_valid,
    input  logic     dec_ready,
    output mul_op_e  dec_op,
    output reg_idx_t dec_rd,
    output xlen_t    dec_a,
    output xlen_t    dec_b,
    output logic     illegal
);

    logic       accept;
    logic       is_mul;
    mul_op_e    op_dec;
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    // Instruction fields used by the decode
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // The stage takes a new entry when it is empty or when its entry leaves now
    assign in_ready = !dec_valid || dec_ready;
    assign accept   = in_valid && in_ready;

    // Map the instruction to a multiply operation
    // Divide and remainder codes fall through and stay illegal here
    always_comb begin
        is_mul = 1'b0;
        op_dec = MUL;
        if (funct7 == F7_MULDIV) begin
            if (opcode == OPC_OP) begin
                case (funct3)
                    3'd0: begin
                        is_mul = 1'b1;
                        op_dec = MUL;
                    end
                    3'd1: begin
                        is_mul = 1'b1;
                        op_dec = MULH;
                    end
                    3'd2: begin
                        is_mul = 1'b1;
                        op_dec = MULHSU;
                    end
                    3'd3: begin
                        is_mul = 1'b1;
                        op_dec = MULHU;
                    end
                    default: is_mul = 1'b0;
                endcase
            end else if (opcode == OPC_OP32 && funct3 == 3'd0) begin
                is_mul = 1'b1;
                op_dec = MULW;
            end
        end
    end

    // Valid flag of the output stage and the one-cycle illegal pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            illegal <= accept && !is_mul;
            if (accept) begin
                // A non-multiply leaves the stage empty
                dec_valid <= is_mul;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
        end
    end

    // Payload of the output stage, loaded only for a legal multiply
    always_ff @(posedge clk) begin
        if (accept && is_mul) begin
            dec_op <= op_dec;
            dec_rd <= instr[11:7];
            dec_a  <= rs1_val;
            dec_b  <= rs2_val;
        end
    end

    // A stalled request must not change under the FIFO
    a_dec_stable: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_op) &&
            $stable(dec_rd) && $stable(dec_a) && $stable(dec_b));

endmodule

/* src/mul_pkg.sv */
// Shared types for the multiply unit of the 64-bit core
package mul_pkg;

    // Register value as seen by operands and results
    typedef logic [63:0] xlen_t;

    // Destination register index, also the tag that follows a request
    typedef logic [4:0] reg_idx_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Multiply operations, the first four follow the funct3 encoding of OP
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        MULW   = 3'd4
    } mul_op_e;

    // Multiplier states
    // Bit 1 selects the upper half of operand 1 and bit 0 the upper half of
    // operand 2, so the step encodings drive the partial product muxes directly
    typedef enum logic [2:0] {
        LL   = 3'b000,
        LH   = 3'b001,
        HL   = 3'b010,
        HH   = 3'b011,
        IDLE = 3'b100
    } mul_state_e;

    // Major opcodes that can carry a multiply
    localparam logic [6:0] OPC_OP   = 7'b0110011;
    localparam logic [6:0] OPC_OP32 = 7'b0111011;

    // Funct7 value shared by all M-extension instructions
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage
